//--- logic/fsync_settings.svh
// Fixed sizing for the fractal barrier sync core
// Port count, presence table size, request field widths
// FIFO depth and the packed widths of both queue words

`ifndef FSYNC_SETTINGS_SVH
`define FSYNC_SETTINGS_SVH

// Receive ports on this 1D node
`define FSYNC_N_PORTS 2

// Entries per presence table
`define FSYNC_N_REGS 6

// Request fields
`define FSYNC_ID_W   3 // Barrier id
`define FSYNC_AGGR_W 4 // Aggregation mask
`define FSYNC_LVL_W  2 // Encoded level, log2 of mask width
`define FSYNC_SRC_W  2 // Source tag

// Entries per output queue
`define FSYNC_FIFO_DEPTH 2

// Local response word {wake, error, dst}
`define FSYNC_RSP_W (1 + 1 + `FSYNC_SRC_W)
// Remote request word {aggr, id, src, 2'b11}
`define FSYNC_REQ_W (`FSYNC_AGGR_W + `FSYNC_ID_W + `FSYNC_SRC_W + 2)

`endif

//--- logic/fsync_pkg.sv
// Shared types of the fractal barrier sync core
// Port controller state encoding
// Kind of presence table access issued per port

package fsync_pkg;

  // Handshake controller states
  typedef enum logic [1:0] {
    IDLE    = 2'b00, // Waiting for req
    CHECK   = 2'b01, // Accepted, table access done
    RELEASE = 2'b10  // Ack held until req drops
  } ctrl_state_e;

  // Which table a port touches this cycle
  typedef enum logic [1:0] {
    CHK_NONE   = 2'b00, // No access
    CHK_LOCAL  = 2'b01, // Root arrival, local table
    CHK_REMOTE = 2'b10  // Aggregate arrival, remote table
  } chk_kind_e;

  // Local table completions are answered downwards,
  // remote table completions move one level up the tree

endpackage

//--- logic/fsync_fifo.sv
// Small circular FIFO for the sync core output queues
// Read and write pointers plus an occupancy count
// Push when full and pop when empty are ignored

`timescale 1ns/1ps

`include "fsync_settings.svh"

module fsync_fifo #(
  parameter int unsigned WIDTH = 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o,
  output logic             full_o
);

  localparam int unsigned DEPTH = `FSYNC_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             do_push;
  logic             do_pop;

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign do_push = push_i & ~full_o;  // Drop on overflow
  assign do_pop  = pop_i & ~empty_o;  // Underflow leaves state alone
  assign data_o  = mem_q[rd_ptr_q];   // Head, valid while not empty

  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_reg
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the count
      if (do_push && !do_pop)      cnt_q <= cnt_q + 1'b1;
      else if (do_pop && !do_push) cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin : mem_write
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

//--- logic/fsync_rf.sv
// Presence tables of the sync core
// Valid bit and stored level per id, local and remote table
// Ports evaluated in index order, later ports see earlier updates
// Id range and level signature errors leave the table unchanged

`timescale 1ns/1ps

`include "fsync_settings.svh"

module fsync_rf (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  fsync_pkg::chk_kind_e     chk_kind_i [`FSYNC_N_PORTS],
  input  logic [`FSYNC_LVL_W-1:0]  level_i    [`FSYNC_N_PORTS],
  input  logic [`FSYNC_ID_W-1:0]   id_i       [`FSYNC_N_PORTS],
  output logic                     present_o  [`FSYNC_N_PORTS],
  output logic                     err_o      [`FSYNC_N_PORTS]
);

  import fsync_pkg::*;

  // Index 0 local table, index 1 remote table
  logic [`FSYNC_N_REGS-1:0] vld_q [2];
  logic [`FSYNC_N_REGS-1:0] vld_d [2];
  logic [`FSYNC_LVL_W-1:0]  lvl_q [2][`FSYNC_N_REGS];
  logic [`FSYNC_LVL_W-1:0]  lvl_d [2][`FSYNC_N_REGS];

  always_comb begin : lookup
    int unsigned tbl;
    int unsigned idx;
    vld_d = vld_q;
    lvl_d = lvl_q;
    for (int p = 0; p < `FSYNC_N_PORTS; p++) begin
      present_o[p] = 1'b0;
      err_o[p]     = 1'b0;
      tbl          = (chk_kind_i[p] == CHK_REMOTE) ? 1 : 0;
      idx          = id_i[p];
      if (chk_kind_i[p] != CHK_NONE) begin
        if (idx >= `FSYNC_N_REGS) begin
          err_o[p] = 1'b1; // Id outside table
        end else if (vld_d[tbl][idx]) begin
          present_o[p] = 1'b1; // Partner already arrived
          if (lvl_d[tbl][idx] != level_i[p]) begin
            err_o[p] = 1'b1; // Signature mismatch keeps the entry
          end else begin
            vld_d[tbl][idx] = 1'b0; // Barrier complete
          end
        end else begin
          // First arrival stores its level
          vld_d[tbl][idx] = 1'b1;
          lvl_d[tbl][idx] = level_i[p];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : vld_reg
    if (!rst_ni) begin
      vld_q[0] <= '0;
      vld_q[1] <= '0;
    end else begin
      vld_q <= vld_d;
    end
  end

  // Stored level per entry
  always_ff @(posedge clk_i) begin : lvl_reg
    lvl_q <= lvl_d;
  end

endmodule

//--- logic/fsync_port_ctrl.sv
// Per-port request handler of the sync core
// Four-phase req/ack FSM, mask to level priority encoder
// Completion decision from table lookup, response and forward words

`timescale 1ns/1ps

`include "fsync_settings.svh"

module fsync_port_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Request side
  input  logic                        req_i,
  input  logic [`FSYNC_AGGR_W-1:0]    aggr_i,
  input  logic [`FSYNC_ID_W-1:0]      id_i,
  input  logic [`FSYNC_SRC_W-1:0]     src_i,
  input  logic                        local_i,
  input  logic                        root_i,
  output logic                        ack_o,
  // Table access
  output fsync_pkg::chk_kind_e        chk_kind_o,
  output logic [`FSYNC_LVL_W-1:0]     level_o,
  output logic [`FSYNC_ID_W-1:0]      id_o,
  input  logic                        present_i,
  input  logic                        err_i,
  // Queue pushes
  output logic                        push_local_o,
  output logic [`FSYNC_RSP_W-1:0]     rsp_o,
  output logic                        push_remote_o,
  output logic [`FSYNC_REQ_W-1:0]     fwd_req_o
);

  import fsync_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        accept; // First cycle req seen high

  always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin : next_state
    state_d = state_q;
    case (state_q)
      IDLE:    if (req_i) state_d = CHECK;
      CHECK:   state_d = req_i ? RELEASE : IDLE; // Fast producer may already be low
      RELEASE: if (!req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  assign accept = (state_q == IDLE) & req_i;
  assign ack_o  = (state_q != IDLE); // High from accept edge to req low edge

  // Highest set mask bit wins
  always_comb begin : level_enc
    level_o = '0;
    for (int j = 0; j < `FSYNC_AGGR_W; j++) begin
      if (aggr_i[j]) level_o = j[`FSYNC_LVL_W-1:0];
    end
  end

  assign id_o = id_i;

  // One table access on the accept cycle only
  always_comb begin : table_select
    chk_kind_o = CHK_NONE;
    if (accept && local_i) begin
      chk_kind_o = root_i ? CHK_LOCAL : CHK_REMOTE;
    end
  end

  // Completion decision, table answers in the same cycle
  always_comb begin : push_decide
    push_local_o  = 1'b0;
    push_remote_o = 1'b0;
    if (chk_kind_o != CHK_NONE) begin
      if (err_i) begin
        push_local_o = 1'b1; // Errors always answered locally
      end else if (present_i) begin
        if (root_i) push_local_o = 1'b1;  // Barrier done at root
        else        push_remote_o = 1'b1; // Forward to parent
      end
    end
  end

  // Wake, error, destination back to requester
  assign rsp_o     = {1'b1, err_i, src_i};
  // Mask one level up, same id, both children as source
  assign fwd_req_o = {aggr_i >> 1, id_i, src_i, 2'b11};

endmodule

//--- logic/fsync_cc.sv
// Top of the 1D fractal barrier sync core
// One handshake controller per receive port
// Shared local and remote presence tables
// Local response and remote request FIFO per port
// Per-port FIFO misuse error flag

`timescale 1ns/1ps

`include "fsync_settings.svh"

module fsync_cc (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Receive ports, four-phase handshake
  input  logic                      req_i            [`FSYNC_N_PORTS],
  input  logic [`FSYNC_AGGR_W-1:0]  aggr_i           [`FSYNC_N_PORTS],
  input  logic [`FSYNC_ID_W-1:0]    id_i             [`FSYNC_N_PORTS],
  input  logic [`FSYNC_SRC_W-1:0]   src_i            [`FSYNC_N_PORTS],
  input  logic                      local_i          [`FSYNC_N_PORTS],
  input  logic                      root_i           [`FSYNC_N_PORTS],
  output logic                      ack_o            [`FSYNC_N_PORTS],
  // Local response queues
  output logic                      local_empty_o    [`FSYNC_N_PORTS],
  output logic [`FSYNC_RSP_W-1:0]   local_rsp_o      [`FSYNC_N_PORTS],
  input  logic                      local_pop_i      [`FSYNC_N_PORTS],
  // Remote request queues
  output logic                      remote_empty_o   [`FSYNC_N_PORTS],
  output logic [`FSYNC_REQ_W-1:0]   remote_req_o     [`FSYNC_N_PORTS],
  input  logic                      remote_pop_i     [`FSYNC_N_PORTS],
  // FIFO misuse
  output logic                      detected_error_o [`FSYNC_N_PORTS]
);

  import fsync_pkg::*;

  chk_kind_e                chk_kind    [`FSYNC_N_PORTS];
  logic [`FSYNC_LVL_W-1:0]  level       [`FSYNC_N_PORTS];
  logic [`FSYNC_ID_W-1:0]   id          [`FSYNC_N_PORTS];
  logic                     present     [`FSYNC_N_PORTS];
  logic                     rf_err      [`FSYNC_N_PORTS];
  logic                     push_local  [`FSYNC_N_PORTS];
  logic [`FSYNC_RSP_W-1:0]  rsp         [`FSYNC_N_PORTS];
  logic                     push_remote [`FSYNC_N_PORTS];
  logic [`FSYNC_REQ_W-1:0]  fwd_req     [`FSYNC_N_PORTS];
  logic                     full_local  [`FSYNC_N_PORTS];
  logic                     full_remote [`FSYNC_N_PORTS];

  for (genvar p = 0; p < `FSYNC_N_PORTS; p++) begin : gen_port
    fsync_port_ctrl i_port_ctrl (
      .clk_i         ( clk_i          ),
      .rst_ni        ( rst_ni         ),
      .req_i         ( req_i[p]       ),
      .aggr_i        ( aggr_i[p]      ),
      .id_i          ( id_i[p]        ),
      .src_i         ( src_i[p]       ),
      .local_i       ( local_i[p]     ),
      .root_i        ( root_i[p]      ),
      .ack_o         ( ack_o[p]       ),
      .chk_kind_o    ( chk_kind[p]    ),
      .level_o       ( level[p]       ),
      .id_o          ( id[p]          ),
      .present_i     ( present[p]     ),
      .err_i         ( rf_err[p]      ),
      .push_local_o  ( push_local[p]  ),
      .rsp_o         ( rsp[p]         ),
      .push_remote_o ( push_remote[p] ),
      .fwd_req_o     ( fwd_req[p]     )
    );

    // Responses back to the requesting children
    fsync_fifo #(
      .WIDTH ( `FSYNC_RSP_W )
    ) i_local_fifo (
      .clk_i   ( clk_i            ),
      .rst_ni  ( rst_ni           ),
      .push_i  ( push_local[p]    ),
      .data_i  ( rsp[p]           ),
      .pop_i   ( local_pop_i[p]   ),
      .data_o  ( local_rsp_o[p]   ),
      .empty_o ( local_empty_o[p] ),
      .full_o  ( full_local[p]    )
    );

    // Aggregated requests towards the parent node
    fsync_fifo #(
      .WIDTH ( `FSYNC_REQ_W )
    ) i_remote_fifo (
      .clk_i   ( clk_i             ),
      .rst_ni  ( rst_ni            ),
      .push_i  ( push_remote[p]    ),
      .data_i  ( fwd_req[p]        ),
      .pop_i   ( remote_pop_i[p]   ),
      .data_o  ( remote_req_o[p]   ),
      .empty_o ( remote_empty_o[p] ),
      .full_o  ( full_remote[p]    )
    );

    // Overflow on push or underflow on pop, either queue
    assign detected_error_o[p] = (push_local[p]    & full_local[p])     |
                                 (push_remote[p]   & full_remote[p])    |
                                 (local_pop_i[p]   & local_empty_o[p])  |
                                 (remote_pop_i[p]  & remote_empty_o[p]);
  end

  // Port 0 resolved ahead of port 1 inside the tables
  fsync_rf i_rf (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .chk_kind_i ( chk_kind ),
    .level_i    ( level    ),
    .id_i       ( id       ),
    .present_o  ( present  ),
    .err_o      ( rf_err   )
  );

endmodule

//--- testbench/fsync_cc_chk.sv
// Bound checker for the sync core top
// Four-phase ack behavior per receive port
// Ack and queue state in the first cycle after reset

`timescale 1ns/1ps

`include "fsync_settings.svh"

module fsync_cc_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic req_i          [`FSYNC_N_PORTS],
  input logic ack_o          [`FSYNC_N_PORTS],
  input logic local_empty_o  [`FSYNC_N_PORTS],
  input logic remote_empty_o [`FSYNC_N_PORTS]
);

  int unsigned fail_cnt = 0; // Assertion failures so far

  for (genvar p = 0; p < `FSYNC_N_PORTS; p++) begin : gen_chk
    // Ack only answers a pending request
    ack_needs_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(ack_o[p]) |-> $past(req_i[p]))
      else begin
        fail_cnt++;
        $error("ack_o[%0d] rose without req_i", p);
      end

    // No early release while req held
    ack_holds : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (ack_o[p] && req_i[p]) |=> ack_o[p])
      else begin
        fail_cnt++;
        $error("ack_o[%0d] dropped while req_i high", p);
      end

    reset_state : assert property (@(posedge clk_i)
      $rose(rst_ni) |-> (!ack_o[p] && local_empty_o[p] && remote_empty_o[p]))
      else begin
        fail_cnt++;
        $error("port %0d not idle after reset", p);
      end
  end

endmodule

bind fsync_cc fsync_cc_chk i_fsync_cc_chk (
  .clk_i          ( clk_i          ),
  .rst_ni         ( rst_ni         ),
  .req_i          ( req_i          ),
  .ack_o          ( ack_o          ),
  .local_empty_o  ( local_empty_o  ),
  .remote_empty_o ( remote_empty_o )
);

//--- testbench/fsync_cc_tb.sv
// Testbench of the fractal barrier sync core
// Clock, reset and DUT, LFSR for random request fields
// Reference model of both presence tables and all output queues
// Directed tests and a closing error count

`timescale 1ns/1ps

`include "fsync_settings.svh"

module fsync_cc_tb;

  localparam int NP  = `FSYNC_N_PORTS;
  localparam int DEP = `FSYNC_FIFO_DEPTH;
  localparam int NID = 1 << `FSYNC_ID_W;
  localparam int TMO = 40; // Cycles allowed per wait

  logic                     clk_i;
  logic                     rst_ni;
  logic                     req_i            [NP];
  logic [`FSYNC_AGGR_W-1:0] aggr_i           [NP];
  logic [`FSYNC_ID_W-1:0]   id_i             [NP];
  logic [`FSYNC_SRC_W-1:0]  src_i            [NP];
  logic                     local_i          [NP];
  logic                     root_i           [NP];
  logic                     ack_o            [NP];
  logic                     local_empty_o    [NP];
  logic [`FSYNC_RSP_W-1:0]  local_rsp_o      [NP];
  logic                     local_pop_i      [NP];
  logic                     remote_empty_o   [NP];
  logic [`FSYNC_REQ_W-1:0]  remote_req_o     [NP];
  logic                     remote_pop_i     [NP];
  logic                     detected_error_o [NP];

  // Model state with table 0 and queue 0 local, table 1 and queue 1 remote
  logic                     mdl_vld [2][NID];
  logic [`FSYNC_LVL_W-1:0]  mdl_lvl [2][NID];
  logic [`FSYNC_REQ_W-1:0]  mdl_q   [NP][2][DEP];
  int                       mdl_n   [NP][2];
  int                       misuse_hits [NP]; // Cycles with detected_error_o high
  int                       errors;
  int                       checks;
  logic [31:0]              lfsr;

  fsync_cc i_fsync_cc (.*);

  always #10 clk_i = ~clk_i;

  always @(negedge clk_i) begin : count_misuse
    for (int p = 0; p < NP; p++) begin
      if (detected_error_o[p] === 1'b1) misuse_hits[p]++;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: time %0t %s got 'h%0h expected 'h%0h", $time, name, got, exp);
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // Level is the index of the top set mask bit
  function automatic logic [`FSYNC_LVL_W-1:0] mask_level(input logic [`FSYNC_AGGR_W-1:0] m);
    for (int j = `FSYNC_AGGR_W - 1; j > 0; j--) begin
      if (m[j]) return j[`FSYNC_LVL_W-1:0];
    end
    return '0; // Bit 0 only or empty mask
  endfunction

  task automatic expect_item(input int p, input int q, input logic [`FSYNC_REQ_W-1:0] w);
    if (mdl_n[p][q] < DEP) begin // Full queue drops the item
      mdl_q[p][q][mdl_n[p][q]] = w;
      mdl_n[p][q]++;
    end
  endtask

  // Completion rule for one accepted request with local_i high
  task automatic model_arrival(input int p, input logic [`FSYNC_AGGR_W-1:0] a,
                               input logic [`FSYNC_ID_W-1:0] i,
                               input logic [`FSYNC_SRC_W-1:0] s, input logic r);
    int                      t;
    logic [`FSYNC_LVL_W-1:0] lv;
    t  = r ? 0 : 1;
    lv = mask_level(a);
    if (i >= `FSYNC_N_REGS || (mdl_vld[t][i] && mdl_lvl[t][i] != lv)) begin
      expect_item(p, 0, {1'b1, 1'b1, s}); // Errors always go to the local queue
    end else if (!mdl_vld[t][i]) begin
      mdl_vld[t][i] = 1'b1; // First arrival
      mdl_lvl[t][i] = lv;
    end else begin
      mdl_vld[t][i] = 1'b0;
      if (r) expect_item(p, 0, {1'b1, 1'b0, s});
      else   expect_item(p, 1, {a >> 1, i, s, 2'b11}); // One level up
    end
  endtask

  task automatic wait_ack(input int p, input logic level);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (ack_o[p] !== level && n < TMO);
    if (ack_o[p] !== level) begin
      errors++;
      $display("timeout: ack_o[%0d] did not go to %0b within %0d cycles", p, level, TMO);
    end
  endtask

  // Full four-phase transfer on one port
  task automatic send_request(input int p, input logic [`FSYNC_AGGR_W-1:0] a,
                              input logic [`FSYNC_ID_W-1:0] i, input logic [`FSYNC_SRC_W-1:0] s,
                              input logic l, input logic r);
    @(posedge clk_i);
    req_i[p]   <= 1'b1;
    aggr_i[p]  <= a;
    id_i[p]    <= i;
    src_i[p]   <= s;
    local_i[p] <= l;
    root_i[p]  <= r;
    wait_ack(p, 1'b1);
    @(posedge clk_i);
    req_i[p] <= 1'b0;
    wait_ack(p, 1'b0);
    if (l) model_arrival(p, a, i, s, r);
  endtask

  // Both ports accepted at the same edge, port 0 ordered first
  task automatic send_pair(input logic [`FSYNC_AGGR_W-1:0] a,
                           input logic [`FSYNC_ID_W-1:0] i, input logic r);
    @(posedge clk_i);
    for (int p = 0; p < NP; p++) begin
      req_i[p]   <= 1'b1;
      aggr_i[p]  <= a;
      id_i[p]    <= i;
      src_i[p]   <= p[`FSYNC_SRC_W-1:0] + 1'b1; // Distinct sources per port
      local_i[p] <= 1'b1;
      root_i[p]  <= r;
    end
    wait_ack(0, 1'b1);
    wait_ack(1, 1'b1);
    @(posedge clk_i);
    req_i[0] <= 1'b0;
    req_i[1] <= 1'b0;
    wait_ack(0, 1'b0);
    wait_ack(1, 1'b0);
    for (int p = 0; p < NP; p++) begin
      model_arrival(p, a, i, p[`FSYNC_SRC_W-1:0] + 1'b1, r);
    end
  endtask

  task automatic pop_and_compare(input int p, input int q);
    @(negedge clk_i);
    if (q == 0) begin
      check_value($sformatf("local_empty_o[%0d]", p), local_empty_o[p], 0);
      check_value($sformatf("local_rsp_o[%0d]", p), local_rsp_o[p], mdl_q[p][0][0]);
    end else begin
      check_value($sformatf("remote_empty_o[%0d]", p), remote_empty_o[p], 0);
      check_value($sformatf("remote_req_o[%0d]", p), remote_req_o[p], mdl_q[p][1][0]);
    end
    @(posedge clk_i);
    local_pop_i[p]  <= (q == 0);
    remote_pop_i[p] <= (q == 1);
    @(posedge clk_i);
    local_pop_i[p]  <= 1'b0;
    remote_pop_i[p] <= 1'b0;
    for (int k = 1; k < DEP; k++) begin
      mdl_q[p][q][k-1] = mdl_q[p][q][k];
    end
    mdl_n[p][q]--;
  endtask

  // Pop every expected item and expect all queues empty afterwards
  task automatic drain_and_check();
    for (int p = 0; p < NP; p++) begin
      for (int q = 0; q < 2; q++) begin
        while (mdl_n[p][q] > 0) pop_and_compare(p, q);
      end
    end
    @(negedge clk_i);
    for (int p = 0; p < NP; p++) begin
      check_value($sformatf("local_empty_o[%0d]", p), local_empty_o[p], 1);
      check_value($sformatf("remote_empty_o[%0d]", p), remote_empty_o[p], 1);
    end
  endtask

  task automatic check_misuse(input int exp0, input int exp1);
    check_value("detected_error_o[0] cycles", misuse_hits[0], exp0);
    check_value("detected_error_o[1] cycles", misuse_hits[1], exp1);
    misuse_hits[0] = 0;
    misuse_hits[1] = 0;
  endtask

  task automatic check_reset_state();
    @(negedge clk_i);
    for (int p = 0; p < NP; p++) begin
      check_value($sformatf("ack_o[%0d]", p), ack_o[p], 0);
      check_value($sformatf("local_empty_o[%0d]", p), local_empty_o[p], 1);
      check_value($sformatf("remote_empty_o[%0d]", p), remote_empty_o[p], 1);
      check_value($sformatf("detected_error_o[%0d]", p), detected_error_o[p], 0);
    end
  endtask

  task automatic root_completion();
    send_request(0, 4'b0100, 3'd3, 2'd1, 1'b1, 1'b1);
    drain_and_check(); // First arrival pushes nothing
    send_request(1, 4'b0110, 3'd3, 2'd2, 1'b1, 1'b1);
    check_value("local_rsp_o[1]", local_rsp_o[1], {1'b1, 1'b0, 2'd2});
    drain_and_check();
    send_pair(4'b0011, 3'd1, 1'b1); // Port 1 completes on port 0's entry
    drain_and_check();
    check_misuse(0, 0);
  endtask

  task automatic nonroot_forwarding();
    send_request(1, 4'b1000, 3'd5, 2'd3, 1'b1, 1'b0);
    drain_and_check();
    send_request(0, 4'b1001, 3'd5, 2'd0, 1'b1, 1'b0); // Port 0 completes
    check_value("remote_req_o[0]", remote_req_o[0], {4'b0100, 3'd5, 2'd0, 2'b11});
    drain_and_check();
    check_misuse(0, 0);
  endtask

  task automatic error_responses();
    send_request(0, 4'b0001, 3'd6, 2'd3, 1'b1, 1'b1); // Id past the table
    check_value("local_rsp_o[0]", local_rsp_o[0], {1'b1, 1'b1, 2'd3});
    send_request(1, 4'b0010, 3'd7, 2'd1, 1'b1, 1'b0); // Remote path answered locally
    drain_and_check();
    send_request(0, 4'b0001, 3'd2, 2'd0, 1'b1, 1'b1);
    send_request(1, 4'b0100, 3'd2, 2'd1, 1'b1, 1'b1); // Level mismatch
    check_value("local_rsp_o[1]", local_rsp_o[1], {1'b1, 1'b1, 2'd1});
    drain_and_check();
    send_request(1, 4'b0001, 3'd2, 2'd2, 1'b1, 1'b1); // Entry kept and completes now
    check_value("local_rsp_o[1]", local_rsp_o[1], {1'b1, 1'b0, 2'd2});
    drain_and_check();
    send_request(0, 4'b0001, 3'd4, 2'd0, 1'b0, 1'b1); // No effect with local_i low
    send_request(1, 4'b0001, 3'd4, 2'd1, 1'b1, 1'b1);
    drain_and_check();
    send_request(0, 4'b0001, 3'd4, 2'd3, 1'b1, 1'b1);
    drain_and_check();
    check_misuse(0, 0);
  endtask

  task automatic fifo_misuse();
    @(posedge clk_i);
    local_pop_i[0]  <= 1'b1; // Both queues empty here
    remote_pop_i[1] <= 1'b1;
    @(negedge clk_i);
    check_value("detected_error_o[0]", detected_error_o[0], 1);
    check_value("detected_error_o[1]", detected_error_o[1], 1);
    @(posedge clk_i);
    local_pop_i[0]  <= 1'b0;
    remote_pop_i[1] <= 1'b0;
    check_misuse(1, 1);
    // Third completion hits a full queue on port 1
    for (int k = 0; k < 3; k++) begin
      send_request(0, 4'b0010, 3'(k), 2'd0, 1'b1, 1'b1);
      send_request(1, 4'b0010, 3'(k), 2'd1, 1'b1, 1'b1);
    end
    check_misuse(0, 1);
    drain_and_check(); // Only two items come out
  endtask

  task automatic random_sequence();
    logic [31:0] v;
    for (int n = 0; n < 60; n++) begin
      v = rand_bits(13); // Port, mask, id, src, local pair, root
      send_request(int'(v[12]), v[8 +: `FSYNC_AGGR_W], v[5 +: `FSYNC_ID_W],
                   v[3 +: `FSYNC_SRC_W], v[2:1] != 2'b00, v[0]); // Mostly local
      drain_and_check();
    end
    check_misuse(0, 0);
  endtask

  initial begin : run
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    lfsr   = 32'had9c;
    errors = 0;
    checks = 0;
    for (int p = 0; p < NP; p++) begin
      req_i[p]        = 1'b0;
      aggr_i[p]       = '0;
      id_i[p]         = '0;
      src_i[p]        = '0;
      local_i[p]      = 1'b0;
      root_i[p]       = 1'b0;
      local_pop_i[p]  = 1'b0;
      remote_pop_i[p] = 1'b0;
      misuse_hits[p]  = 0;
      mdl_n[p][0]     = 0;
      mdl_n[p][1]     = 0;
    end
    for (int k = 0; k < NID; k++) begin
      mdl_vld[0][k] = 1'b0;
      mdl_vld[1][k] = 1'b0;
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    check_reset_state();
    root_completion();
    nonroot_forwarding();
    error_responses();
    fifo_misuse();
    random_sequence();
    errors = errors + i_fsync_cc.i_fsync_cc_chk.fail_cnt;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+logic
logic/fsync_pkg.sv
logic/fsync_fifo.sv
logic/fsync_rf.sv
logic/fsync_port_ctrl.sv
logic/fsync_cc.sv
testbench/fsync_cc_chk.sv
testbench/fsync_cc_tb.sv
